/* hw/bpu_pkg.sv */
`default_nettype none

package bpu_pkg;

    localparam int XLEN     = 32;
    localparam int FT_OFF_W = 5;  // fallthrough offset, holds 2 to 16.
    localparam int TAG_W    = 9;
    localparam int TGT_W    = 11; // target bits 11 down to 1 of the address.
    localparam int GHR_LEN  = 8;

    localparam int UBTB_DEPTH = 32;

    // one fetch block per cycle on a miss.
    localparam logic [XLEN-1:0] FETCH_BYTES = 32'd16;
    localparam logic [XLEN-1:0] RESET_PC    = 32'h0000_1000;

    // every type above BR_COND is an unconditional transfer.
    typedef enum logic [1:0] {
        BR_COND   = 2'd0,
        BR_DIRECT = 2'd1,
        BR_CALL   = 2'd2,
        BR_RET    = 2'd3
    } branch_type_e;

    typedef struct packed {
        logic               valid;
        logic [TAG_W-1:0]   tag;
        logic [FT_OFF_W-1:0] ft_off;
        logic [TGT_W-1:0]   tgt;
        branch_type_e       br_type;
    } ubtb_entry_t;

    typedef struct packed {
        logic            hit;
        logic            taken;
        logic [XLEN-1:0] ft_addr;
        logic [XLEN-1:0] tgt_addr;
        logic [XLEN-1:0] next_addr;
        branch_type_e    br_type;
    } ubtb_pred_t;

    // a resolved fetch block as reported by the back end.
    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] ft_addr;
        logic [XLEN-1:0] tgt_addr;
        logic            taken;
        branch_type_e    br_type;
    } ubtb_update_t;

    // 2-bit saturating counter step.
    function automatic logic [1:0] counter_update(
        input logic [1:0] cnt,
        input logic       taken
    );
        logic [1:0] nxt;
        nxt = cnt;
        if (taken) begin
            if (cnt != 2'd3) begin
                nxt = cnt + 2'd1;
            end
        end else begin
            if (cnt != 2'd0) begin
                nxt = cnt - 2'd1;
            end
        end
        return nxt;
    endfunction

endpackage

`default_nettype wire

/* hw/bpu_top.sv */
`default_nettype none

module bpu_top (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         i_update,
    input  bpu_pkg::ubtb_update_t        i_update_info,
    input  logic                         i_redirect,
    input  logic [bpu_pkg::XLEN-1:0]     i_redirect_pc,
    output logic [bpu_pkg::XLEN-1:0]     o_fetch_pc,
    output bpu_pkg::ubtb_pred_t          o_pred,
    output logic [bpu_pkg::GHR_LEN-1:0]  o_spec_ghr
);

    logic [bpu_pkg::XLEN-1:0]    fetch_pc;
    bpu_pkg::ubtb_pred_t         pred;
    logic [bpu_pkg::GHR_LEN-1:0] spec_ghr;
    logic [bpu_pkg::GHR_LEN-1:0] arch_ghr;

    fetch_pc_gen u_fetch_pc_gen (
        .clk           (clk),
        .rst           (rst),
        .i_pred        (pred),
        .i_redirect    (i_redirect),
        .i_redirect_pc (i_redirect_pc),
        .o_fetch_pc    (fetch_pc)
    );

    branch_history u_branch_history (
        .clk           (clk),
        .rst           (rst),
        .i_pred        (pred),
        .i_update      (i_update),
        .i_update_info (i_update_info),
        .i_redirect    (i_redirect),
        .o_spec_ghr    (spec_ghr),
        .o_arch_ghr    (arch_ghr)
    );

    // The lookup is combinational, so the prediction for fetch_pc is ready
    // in the same cycle and closes the loop back into the pc register.
    ubtb #(
        .DEPTH (bpu_pkg::UBTB_DEPTH)
    ) u_ubtb (
        .clk           (clk),
        .rst           (rst),
        .i_lookup_pc   (fetch_pc),
        .i_spec_ghr    (spec_ghr),
        .i_update      (i_update),
        .i_update_info (i_update_info),
        .i_arch_ghr    (arch_ghr),
        .o_pred        (pred)
    );

    assign o_fetch_pc = fetch_pc;
    assign o_pred     = pred;
    assign o_spec_ghr = spec_ghr;

endmodule

`default_nettype wire

/* hw/branch_history.sv */
`default_nettype none

module branch_history (
    input  logic                         clk,
    input  logic                         rst,
    input  bpu_pkg::ubtb_pred_t          i_pred,
    input  logic                         i_update,
    input  bpu_pkg::ubtb_update_t        i_update_info,
    input  logic                         i_redirect,
    output logic [bpu_pkg::GHR_LEN-1:0]  o_spec_ghr,
    output logic [bpu_pkg::GHR_LEN-1:0]  o_arch_ghr
);

    logic [bpu_pkg::GHR_LEN-1:0] spec_q;
    logic [bpu_pkg::GHR_LEN-1:0] arch_q;
    logic [bpu_pkg::GHR_LEN-1:0] spec_d;
    logic [bpu_pkg::GHR_LEN-1:0] arch_d;
    logic                        arch_shift;
    logic                        spec_shift;

    // only conditional branches enter either history.
    assign arch_shift = i_update && (i_update_info.br_type == bpu_pkg::BR_COND);
    assign spec_shift = i_pred.hit && (i_pred.br_type == bpu_pkg::BR_COND);

    always_comb begin
        arch_d = arch_q;
        if (arch_shift) begin
            arch_d = {arch_q[bpu_pkg::GHR_LEN-2:0], i_update_info.taken};
        end
    end

    // A redirect wins over the current prediction, and it restores from the
    // architectural value that includes an update resolving in the same cycle.
    always_comb begin
        spec_d = spec_q;
        if (i_redirect) begin
            spec_d = arch_d;
        end else if (spec_shift) begin
            spec_d = {spec_q[bpu_pkg::GHR_LEN-2:0], i_pred.taken};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            spec_q <= '0;
            arch_q <= '0;
        end else begin
            spec_q <= spec_d;
            arch_q <= arch_d;
        end
    end

    assign o_spec_ghr = spec_q;
    assign o_arch_ghr = arch_q;

endmodule

`default_nettype wire

/* hw/fetch_pc_gen.sv */
`default_nettype none

module fetch_pc_gen (
    input  logic                      clk,
    input  logic                      rst,
    input  bpu_pkg::ubtb_pred_t       i_pred,
    input  logic                      i_redirect,
    input  logic [bpu_pkg::XLEN-1:0]  i_redirect_pc,
    output logic [bpu_pkg::XLEN-1:0]  o_fetch_pc
);

    logic [bpu_pkg::XLEN-1:0] pc_q;
    logic [bpu_pkg::XLEN-1:0] pc_d;

    // the back end overrides whatever the predictor chose this cycle.
    always_comb begin
        if (i_redirect) begin
            pc_d = i_redirect_pc;
        end else begin
            pc_d = i_pred.next_addr;
        end
    end

    // fetch never stalls, so the register loads at every edge.
    always_ff @(posedge clk) begin
        if (rst) begin
            pc_q <= bpu_pkg::RESET_PC;
        end else begin
            pc_q <= pc_d;
        end
    end

    assign o_fetch_pc = pc_q;

    // Instructions start on halfword boundaries, so a restart address
    // with bit 0 set points into the middle of one.
    a_redirect_align: assert property (@(posedge clk) disable iff (rst)
        i_redirect |-> (i_redirect_pc[0] == 1'b0));

endmodule

`default_nettype wire

/* hw/ubtb.sv */
`default_nettype none

module ubtb #(
    parameter int DEPTH = bpu_pkg::UBTB_DEPTH
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic [bpu_pkg::XLEN-1:0]     i_lookup_pc,
    input  logic [bpu_pkg::GHR_LEN-1:0]  i_spec_ghr,
    input  logic                         i_update,
    input  bpu_pkg::ubtb_update_t        i_update_info,
    input  logic [bpu_pkg::GHR_LEN-1:0]  i_arch_ghr,
    output bpu_pkg::ubtb_pred_t          o_pred
);

    localparam int PHT_DEPTH = 2 * DEPTH;
    localparam int IDX_W     = $clog2(DEPTH);
    localparam int PHT_IDX_W = $clog2(PHT_DEPTH);

    bpu_pkg::ubtb_entry_t entries [DEPTH];
    logic [1:0]           pht     [PHT_DEPTH];

    // the same hashes serve the lookup and the update side.
    function automatic logic [IDX_W-1:0] btb_index(input logic [bpu_pkg::XLEN-1:0] pc);
        return pc[IDX_W+1:2];
    endfunction

    function automatic logic [PHT_IDX_W-1:0] pht_index(
        input logic [bpu_pkg::XLEN-1:0]    pc,
        input logic [bpu_pkg::GHR_LEN-1:0] ghr
    );
        return pc[PHT_IDX_W+1:2] ^ PHT_IDX_W'(ghr); // low history bits only.
    endfunction

    function automatic logic [bpu_pkg::TAG_W-1:0] tag_hash(
        input logic [bpu_pkg::XLEN-1:0] pc
    );
        return pc[bpu_pkg::TAG_W:1] ^ pc[2*bpu_pkg::TAG_W:bpu_pkg::TAG_W+1];
    endfunction

    logic [IDX_W-1:0]              rd_idx;
    logic [PHT_IDX_W-1:0]          rd_pht_idx;
    logic [bpu_pkg::TAG_W-1:0]     rd_tag;
    bpu_pkg::ubtb_entry_t          rd_entry;
    logic [1:0]                    rd_cnt;
    logic                          rd_hit;
    logic                          rd_taken;
    logic [bpu_pkg::XLEN-1:0]      rd_ft_addr;
    logic [bpu_pkg::XLEN-1:0]      rd_tgt_addr;

    assign rd_idx     = btb_index(i_lookup_pc);
    assign rd_pht_idx = pht_index(i_lookup_pc, i_spec_ghr);
    assign rd_tag     = tag_hash(i_lookup_pc);
    assign rd_entry   = entries[rd_idx];
    assign rd_cnt     = pht[rd_pht_idx];

    assign rd_hit   = rd_entry.valid && (rd_entry.tag == rd_tag);
    assign rd_taken = rd_hit && ((rd_entry.br_type != bpu_pkg::BR_COND) || (rd_cnt >= 2'd2));

    // a miss falls through to the next fetch block.
    assign rd_ft_addr = rd_hit
        ? i_lookup_pc + {{(bpu_pkg::XLEN-bpu_pkg::FT_OFF_W){1'b0}}, rd_entry.ft_off}
        : i_lookup_pc + bpu_pkg::FETCH_BYTES;

    assign rd_tgt_addr = {i_lookup_pc[bpu_pkg::XLEN-1:bpu_pkg::TGT_W+1], rd_entry.tgt, 1'b0};

    always_comb begin
        o_pred.hit       = rd_hit;
        o_pred.taken     = rd_taken;
        o_pred.ft_addr   = rd_ft_addr;
        o_pred.tgt_addr  = rd_tgt_addr;
        o_pred.next_addr = rd_taken ? rd_tgt_addr : rd_ft_addr;
        o_pred.br_type   = rd_entry.br_type;
    end

    logic [IDX_W-1:0]          wr_idx;
    logic [PHT_IDX_W-1:0]      wr_pht_idx;
    logic [bpu_pkg::XLEN-1:0]  wr_span;
    bpu_pkg::ubtb_entry_t      wr_entry;

    assign wr_idx     = btb_index(i_update_info.pc);
    assign wr_pht_idx = pht_index(i_update_info.pc, i_arch_ghr); // trained on the resolved path.
    assign wr_span    = i_update_info.ft_addr - i_update_info.pc;

    always_comb begin
        wr_entry.valid   = 1'b1;
        wr_entry.tag     = tag_hash(i_update_info.pc);
        wr_entry.ft_off  = wr_span[bpu_pkg::FT_OFF_W-1:0];
        wr_entry.tgt     = i_update_info.tgt_addr[bpu_pkg::TGT_W:1];
        wr_entry.br_type = i_update_info.br_type;
    end

    // an update replaces the whole entry, whatever was there.
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < DEPTH; i++) begin
                entries[i].valid <= 1'b0;
            end
        end else if (i_update) begin
            entries[wr_idx] <= wr_entry;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < PHT_DEPTH; i++) begin
                pht[i] <= 2'd1; // weakly not taken.
            end
        end else if (i_update && (i_update_info.br_type == bpu_pkg::BR_COND)) begin
            pht[wr_pht_idx] <= bpu_pkg::counter_update(pht[wr_pht_idx], i_update_info.taken);
        end
    end

    // the back end only reports blocks that fit the offset field.
    a_upd_span: assert property (@(posedge clk) disable iff (rst)
        i_update |-> (wr_span >= 2) && (wr_span <= 16));

    a_upd_align: assert property (@(posedge clk) disable iff (rst)
        i_update |-> (i_update_info.pc[0] == 1'b0));

endmodule

`default_nettype wire

/* run.sh */
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and scans the log.

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --top-module tb_bpu -f tb.f -o sim_bpu > build.log 2>&1 \
    && ./obj_dir/sim_bpu > "$LOG" 2>&1 \
    || { echo "build or simulation error, see build.log and $LOG"; exit 1; }

cat "$LOG"
grep -q "Verification failed" "$LOG" && exit 1
exit 0

/* tb.f */
hw/bpu_pkg.sv
hw/ubtb.sv
hw/branch_history.sv
hw/fetch_pc_gen.sv
hw/bpu_top.sv
testbench/tb_bpu.sv

/* testbench/tb_bpu.sv */
`default_nettype none

module tb_bpu;

    localparam int IDX_W     = $clog2(bpu_pkg::UBTB_DEPTH);
    localparam int PHT_DEPTH = 2 * bpu_pkg::UBTB_DEPTH;
    localparam int PHT_IDX_W = $clog2(PHT_DEPTH);
    localparam int CYCLE     = 20;

    logic                          clk;
    logic                          rst;
    logic                          i_update;
    bpu_pkg::ubtb_update_t         i_update_info;
    logic                          i_redirect;
    logic [bpu_pkg::XLEN-1:0]      i_redirect_pc;
    logic [bpu_pkg::XLEN-1:0]      o_fetch_pc;
    bpu_pkg::ubtb_pred_t           o_pred;
    logic [bpu_pkg::GHR_LEN-1:0]   o_spec_ghr;

    bpu_top UUT (
        .clk           (clk),
        .rst           (rst),
        .i_update      (i_update),
        .i_update_info (i_update_info),
        .i_redirect    (i_redirect),
        .i_redirect_pc (i_redirect_pc),
        .o_fetch_pc    (o_fetch_pc),
        .o_pred        (o_pred),
        .o_spec_ghr    (o_spec_ghr)
    );

    always #(CYCLE / 2) clk = ~clk;

    // reference model state.
    logic                          m_valid  [bpu_pkg::UBTB_DEPTH];
    logic [bpu_pkg::TAG_W-1:0]     m_tag    [bpu_pkg::UBTB_DEPTH];
    logic [bpu_pkg::FT_OFF_W-1:0]  m_ft_off [bpu_pkg::UBTB_DEPTH];
    logic [bpu_pkg::TGT_W-1:0]     m_tgt    [bpu_pkg::UBTB_DEPTH];
    bpu_pkg::branch_type_e         m_type   [bpu_pkg::UBTB_DEPTH];
    logic [1:0]                    m_cnt    [PHT_DEPTH];
    logic [bpu_pkg::GHR_LEN-1:0]   m_spec;
    logic [bpu_pkg::GHR_LEN-1:0]   m_arch;
    logic [bpu_pkg::XLEN-1:0]      m_pc;

    logic [bpu_pkg::XLEN-1:0]      pool [8];
    logic [31:0]                   lfsr;
    int                            errors;
    int                            checks;
    int                            tests_run;
    int                            tests_bad;
    logic                          timed_out;

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic [31:0] n;
        if (s[0]) begin
            n = (s >> 1) ^ 32'h8020_0003;
        end else begin
            n = s >> 1;
        end
        return n;
    endfunction

    // the LFSR steps once per bit taken and the newest bit lands in the lsb.
    task automatic rand_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[30:0], lfsr[0]};
        end
    endtask

    function automatic logic [bpu_pkg::TAG_W-1:0] tag_of(input logic [bpu_pkg::XLEN-1:0] pc);
        return pc[9:1] ^ pc[18:10];
    endfunction

    function automatic bpu_pkg::ubtb_pred_t lookup(
        input logic [bpu_pkg::XLEN-1:0]    pc,
        input logic [bpu_pkg::GHR_LEN-1:0] ghr
    );
        bpu_pkg::ubtb_pred_t  p;
        logic [IDX_W-1:0]     i;
        logic [PHT_IDX_W-1:0] c;
        i = pc[IDX_W+1:2];
        c = pc[PHT_IDX_W+1:2] ^ ghr[PHT_IDX_W-1:0];
        p.hit = m_valid[i] && (m_tag[i] == tag_of(pc));
        p.taken = p.hit && ((m_type[i] != bpu_pkg::BR_COND) || (m_cnt[c] >= 2'd2));
        p.ft_addr = p.hit ? pc + 32'(m_ft_off[i]) : pc + bpu_pkg::FETCH_BYTES;
        p.tgt_addr = {pc[31:12], m_tgt[i], 1'b0};
        p.next_addr = p.taken ? p.tgt_addr : p.ft_addr;
        p.br_type = m_type[i];
        return p;
    endfunction

    task automatic model_reset();
        m_valid = '{default: 1'b0};
        m_cnt   = '{default: 2'd1};
        m_spec  = '0;
        m_arch  = '0;
        m_pc    = bpu_pkg::RESET_PC;
    endtask

    // advances the model across one rising edge with the inputs of that cycle.
    task automatic model_step(input logic upd, input bpu_pkg::ubtb_update_t info,
                              input logic redir, input logic [bpu_pkg::XLEN-1:0] rpc);
        bpu_pkg::ubtb_pred_t         p;
        logic [bpu_pkg::GHR_LEN-1:0] arch_n;
        logic [IDX_W-1:0]            wi;
        logic [PHT_IDX_W-1:0]        wc;
        logic [bpu_pkg::XLEN-1:0]    span;
        p = lookup(m_pc, m_spec);
        arch_n = m_arch;
        if (upd && info.br_type == bpu_pkg::BR_COND) begin
            arch_n = {m_arch[bpu_pkg::GHR_LEN-2:0], info.taken};
        end
        if (redir) begin
            m_spec = arch_n;
        end else if (p.hit && p.br_type == bpu_pkg::BR_COND) begin
            m_spec = {m_spec[bpu_pkg::GHR_LEN-2:0], p.taken};
        end
        if (upd) begin
            wi = info.pc[IDX_W+1:2];
            wc = info.pc[PHT_IDX_W+1:2] ^ m_arch[PHT_IDX_W-1:0];
            span = info.ft_addr - info.pc;
            m_valid[wi]  = 1'b1;
            m_tag[wi]    = tag_of(info.pc);
            m_ft_off[wi] = span[bpu_pkg::FT_OFF_W-1:0];
            m_tgt[wi]    = info.tgt_addr[11:1];
            m_type[wi]   = info.br_type;
            if (info.br_type == bpu_pkg::BR_COND) begin
                if (info.taken && m_cnt[wc] != 2'd3) begin
                    m_cnt[wc] = m_cnt[wc] + 2'd1;
                end else if (!info.taken && m_cnt[wc] != 2'd0) begin
                    m_cnt[wc] = m_cnt[wc] - 2'd1;
                end
            end
        end
        m_arch = arch_n;
        m_pc = redir ? rpc : p.next_addr;
    endtask

    task automatic check_pred(input bpu_pkg::ubtb_pred_t got, input bpu_pkg::ubtb_pred_t exp);
        checks++;
        // target and type are only meaningful on a hit.
        if (got.hit !== exp.hit || got.taken !== exp.taken || got.ft_addr !== exp.ft_addr
            || got.next_addr !== exp.next_addr
            || (exp.hit && (got.tgt_addr !== exp.tgt_addr || got.br_type !== exp.br_type))) begin
            errors++;
            $display("Error: o_pred = %h, expected %h at %0t", got, exp, $time);
        end
    endtask

    task automatic check_addr(input string name, input logic [bpu_pkg::XLEN-1:0] got,
                              input logic [bpu_pkg::XLEN-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error: %s = %h, expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_ghr(input string name, input logic [bpu_pkg::GHR_LEN-1:0] got,
                             input logic [bpu_pkg::GHR_LEN-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error: %s = %h, expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_budget(input string name, input time t0, input int n);
        if ($time - t0 > time'((n + 2) * CYCLE)) begin
            timed_out = 1'b1;
            $display("Timeout: %s did not get through its %0d cycles in time", name, n);
        end
    endtask

    // entered and left 2 time units after a rising edge.
    task automatic tick(input logic upd, input bpu_pkg::ubtb_update_t info,
                        input logic redir, input logic [bpu_pkg::XLEN-1:0] rpc);
        i_update      = upd;
        i_update_info = info;
        i_redirect    = redir;
        i_redirect_pc = rpc;
        @(posedge clk);
        model_step(upd, info, redir, rpc);
        #1;
        check_addr("o_fetch_pc", o_fetch_pc, m_pc);
        check_ghr("o_spec_ghr", o_spec_ghr, m_spec);
        check_pred(o_pred, lookup(m_pc, m_spec));
        #1;
    endtask

    task automatic make_update(input logic [bpu_pkg::XLEN-1:0] pc,
                               input bpu_pkg::branch_type_e t, input logic taken,
                               output bpu_pkg::ubtb_update_t u);
        logic [31:0] r;
        rand_bits(4, r);
        u.pc = pc;
        u.ft_addr = pc + 32'd2 + (r % 32'd15); // 2 to 16 bytes.
        rand_bits(11, r);
        u.tgt_addr = {pc[31:12], r[10:0], 1'b0};
        u.taken = (t == bpu_pkg::BR_COND) ? taken : 1'b1;
        u.br_type = t;
    endtask

    task automatic report_test(input string name, input int err_before);
        tests_run++;
        if (errors == err_before && !timed_out) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            tests_bad++;
            $display("test %0d %s: %0d mismatches", tests_run, name, errors - err_before);
        end
    endtask

    initial begin
        bpu_pkg::ubtb_update_t u;
        bpu_pkg::branch_type_e t;
        logic [31:0]           r;
        logic                  upd;
        logic                  redir;
        logic [2:0]            k;
        time                   t0;
        int                    n;
        int                    e0;

        clk = 1'b0;
        rst = 1'b1;
        i_update = 1'b0;
        i_update_info = '0;
        i_redirect = 1'b0;
        i_redirect_pc = '0;
        lfsr = 32'h18f9_ccc6;
        errors = 0;
        checks = 0;
        tests_run = 0;
        tests_bad = 0;
        timed_out = 1'b0;

        // 1000/1080/11080/1100 all share buffer index 0, and 1000 and 11080 share a tag.
        pool[0] = 32'h0000_1000;
        pool[1] = 32'h0000_1080;
        pool[2] = 32'h0001_1080;
        pool[3] = 32'h0000_1100;
        pool[4] = 32'h0000_2010;
        pool[5] = 32'h0000_2090;
        pool[6] = 32'h0000_3024;
        pool[7] = 32'h0000_1ffe;

        t0 = $time;
        n = 0;
        while (n < 3 && !timed_out) begin
            @(posedge clk);
            n++;
            check_budget("reset", t0, 3);
        end
        #2;
        rst = 1'b0;
        model_reset();

        e0 = errors;
        check_addr("o_fetch_pc", o_fetch_pc, bpu_pkg::RESET_PC);
        check_pred(o_pred, lookup(m_pc, m_spec));
        t0 = $time;
        n = 0;
        while (n < 12 && !timed_out) begin
            tick(1'b0, '0, 1'b0, '0);
            n++;
            check_budget("reset and sequential fetch", t0, 12);
        end
        report_test("reset and sequential fetch", e0);

        // each unconditional type is written and fetched in the same cycle.
        e0 = errors;
        t0 = $time;
        n = 0;
        while (n < 12 && !timed_out) begin
            if (n % 4 == 0) begin
                t = bpu_pkg::branch_type_e'(2'(n / 4 + 1));
                make_update(pool[3'(n / 4 + 5)], t, 1'b1, u);
                tick(1'b1, u, 1'b1, pool[3'(n / 4 + 5)]);
            end else begin
                tick(1'b0, '0, 1'b0, '0);
            end
            n++;
            check_budget("unconditional hits", t0, 12);
        end
        report_test("unconditional hits", e0);

        // history fills with ones until one counter saturates.
        // The zeros that follow walk the index back to a counter that steps down.
        e0 = errors;
        t0 = $time;
        n = 0;
        while (n < 24 && !timed_out) begin
            make_update(pool[0], bpu_pkg::BR_COND, n < 12, u);
            tick(1'b1, u, 1'b1, pool[0]);
            n++;
            check_budget("counter saturation", t0, 24);
        end
        report_test("counter saturation", e0);

        e0 = errors;
        t0 = $time;
        n = 0;
        while (n < 16 && !timed_out) begin
            if (n % 2 == 0) begin
                rand_bits(1, r);
                make_update(pool[3], bpu_pkg::BR_COND, r[0], u);
                tick(1'b1, u, 1'b1, pool[3]);
            end else begin
                tick(1'b0, '0, 1'b0, '0);
            end
            n++;
            check_budget("history restore", t0, 16);
        end
        report_test("history restore", e0);

        e0 = errors;
        t0 = $time;
        n = 0;
        while (n < 2000 && !timed_out) begin
            rand_bits(3, r);
            redir = (r < 32'd3);
            rand_bits(3, r);
            k = r[2:0];
            rand_bits(1, r);
            upd = r[0];
            rand_bits(2, r);
            t = bpu_pkg::branch_type_e'(r[1:0]);
            rand_bits(4, r);
            make_update(pool[r[2:0]], t, r[3], u);
            tick(upd, u, redir, pool[k]);
            n++;
            check_budget("random traffic", t0, 2000);
        end
        report_test("random traffic", e0);

        $display("%0d tests, %0d with errors, %0d checks, %0d errors",
                 tests_run, tests_bad, checks, errors);
        if (errors == 0 && !timed_out) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
